/* src.f */
source/tcache_pkg.sv
source/tcache_wr_if.sv
source/tcache_ingress_ctrl.sv
source/tcache_word_packer.sv
source/tcache_l2c_bypass.sv
source/tcache_core.sv
sim/tcache_core_sva.sv
sim/tcache_core_tb.sv

/* Bender.yml */
package:
  name: tcache_core

sources:
  - source/tcache_pkg.sv
  - source/tcache_wr_if.sv
  - source/tcache_ingress_ctrl.sv
  - source/tcache_word_packer.sv
  - source/tcache_l2c_bypass.sv
  - source/tcache_core.sv
  - target: simulation
    files:
      - sim/tcache_core_sva.sv
      - sim/tcache_core_tb.sv

/* sim/tcache_core_tb.sv */
module tcache_core_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int rst_cycles = 8;
   localparam int n_beats    = 24;
   localparam int test_len   = n_beats + 32;   // beats, last latency and drain
   localparam int n_tests    = 14;
   localparam int max_cycles = rst_cycles + n_tests * test_len + 64;

   logic                             clk = 1'b0;
   logic                             rst_n;
   logic [tcache_pkg::mode_w-1:0]    mode;
   logic                             trans_prici;
   logic                             trans_swbank;
   logic                             dfifo_addr_odd;
   logic [4:0]                       mvfmap_offset;
   logic                             mvfmap_stride;
   logic                             l1b_datain_vld_ch0;
   logic                             l1b_datain_vld_ch1;
   logic                             l1b_datain_last;
   tcache_pkg::fmap_word_u           l1b_datain_ch0;
   tcache_pkg::fmap_word_u           l1b_datain_ch1;
   logic                             l2c_datain_vld;
   logic                             l2c_datain_last;
   tcache_pkg::fmap_word_u           l2c_datain;
   logic                             ram_wr_vld;
   logic                             ram_wr_last;
   logic [tcache_pkg::word_bits-1:0] ram_wr_ch0;
   logic [tcache_pkg::word_bits-1:0] ram_wr_ch1;
   logic                             l1b_dataout_vld2lsu;
   logic                             l1b_dataout_vld;
   logic [tcache_pkg::word_bits-1:0] l1b_dataout;

   // reference model state
   logic                             m_vld;
   logic                             m_last;
   logic                             m_hl;
   logic                             m_out_vld;
   logic [tcache_pkg::last_dly-1:0]  m_dly;
   tcache_pkg::fmap_word_u           m_ch0;
   tcache_pkg::fmap_word_u           m_ch1;
   tcache_pkg::fmap_word_u           m_out;

   integer seed = 32'h5b35;
   int     errors = 0;
   int     checks = 0;
   int     tests = 0;
   int     cycles = 0;
   int     test_err0 = 0;
   string  test_name;

   always #5 clk = ~clk;

   tcache_core i_tcache_core (
      .clk                 (clk),
      .rst_n               (rst_n),
      .mode                (mode),
      .trans_prici         (trans_prici),
      .trans_swbank        (trans_swbank),
      .dfifo_addr_odd      (dfifo_addr_odd),
      .mvfmap_offset       (mvfmap_offset),
      .mvfmap_stride       (mvfmap_stride),
      .l1b_datain_vld_ch0  (l1b_datain_vld_ch0),
      .l1b_datain_vld_ch1  (l1b_datain_vld_ch1),
      .l1b_datain_last     (l1b_datain_last),
      .l1b_datain_ch0      (l1b_datain_ch0),
      .l1b_datain_ch1      (l1b_datain_ch1),
      .l2c_datain_vld      (l2c_datain_vld),
      .l2c_datain_last     (l2c_datain_last),
      .l2c_datain          (l2c_datain),
      .ram_wr_vld          (ram_wr_vld),
      .ram_wr_last         (ram_wr_last),
      .ram_wr_ch0          (ram_wr_ch0),
      .ram_wr_ch1          (ram_wr_ch1),
      .l1b_dataout_vld2lsu (l1b_dataout_vld2lsu),
      .l1b_dataout_vld     (l1b_dataout_vld),
      .l1b_dataout         (l1b_dataout)
   );

   function automatic logic is_trans(input logic [tcache_pkg::mode_w-1:0] m);
      return (m == tcache_pkg::mode_trans_matrix) || (m == tcache_pkg::mode_trans_dwconv);
   endfunction

   function automatic tcache_pkg::fmap_word_u rand_word();
      logic [tcache_pkg::word_bits-1:0] v;
      for (int i = 0; i < tcache_pkg::word_bits / 32; i++) begin
         v[i*32 +: 32] = $random(seed);
      end
      return v;
   endfunction

   // even bytes packed low, odd bytes high
   function automatic tcache_pkg::fmap_word_u swizzle(input tcache_pkg::fmap_word_u w);
      tcache_pkg::fmap_word_u s;
      for (int n = 0; n < tcache_pkg::ch_x / 2; n++) begin
         s.bytes[n]                     = w.bytes[2*n];
         s.bytes[n + tcache_pkg::ch_x/2] = w.bytes[2*n + 1];
      end
      return s;
   endfunction

   // advances the model by one rising edge from the inputs driven this cycle
   function automatic void expect_wr();
      logic                   trans;
      logic                   sfifo;
      logic                   beat;
      logic                   last;
      tcache_pkg::fmap_word_u sel;
      tcache_pkg::fmap_word_u n0;
      tcache_pkg::fmap_word_u n1;
      trans = is_trans(mode);
      sfifo = (mode == tcache_pkg::mode_conv16_sfifo) || (mode == tcache_pkg::mode_conv32_sfifo);
      beat  = trans ? l2c_datain_vld : (l1b_datain_vld_ch0 | l1b_datain_vld_ch1);
      last  = trans ? l2c_datain_last : m_dly[tcache_pkg::last_dly-1];
      sel   = l1b_datain_vld_ch0 ? l1b_datain_ch0 : l1b_datain_ch1;
      n0 = m_ch0;
      n1 = m_ch1;
      if (trans) begin
         n0 = trans_prici ? swizzle(l2c_datain) : l2c_datain;
         n1 = n0;
      end else if (mode == tcache_pkg::mode_conv16_dfifo) begin
         n0 = {l1b_datain_ch1.halves[0], l1b_datain_ch0.halves[0]};
         n1 = {l1b_datain_ch1.halves[1], l1b_datain_ch0.halves[1]};
      end else if (sfifo && mvfmap_stride) begin
         n0 = '0;
         n1 = '0;
         if (mode == tcache_pkg::mode_conv16_sfifo) begin
            n0.halves[mvfmap_offset[0]] = sel.halves[0];
            n1.halves[mvfmap_offset[0]] = sel.halves[1];
         end else if (mvfmap_offset[0]) begin
            n1 = sel;
         end else begin
            n0 = sel;
         end
      end else if (mode == tcache_pkg::mode_conv16_sfifo) begin
         if (last && !m_hl) begin   // tail beat without a partner
            n0.halves[0] = sel.halves[0];
            n1.halves[0] = sel.halves[1];
         end else begin
            n0 = {sel.halves[0], m_ch0.halves[1]};
            n1 = {sel.halves[1], m_ch1.halves[1]};
         end
      end else if (mode == tcache_pkg::mode_conv32_sfifo) begin
         if (m_hl) n1 = sel;
         else n0 = sel;
      end else begin
         n0 = l1b_datain_ch0;
         n1 = l1b_datain_ch1;
      end
      if (beat) begin
         m_ch0 = n0;
         m_ch1 = n1;
      end
      m_vld  = (sfifo && !mvfmap_stride) ? ((beat && m_hl) || last) : beat;
      m_last = last;
      if (last) m_hl = 1'b0;
      else if (beat && sfifo) m_hl = ~m_hl;
      m_dly     = {m_dly[tcache_pkg::last_dly-2:0], l1b_datain_last};
      m_out_vld = !trans && l2c_datain_vld;
      if (m_out_vld) begin
         m_out = trans_swbank ? {l2c_datain.halves[0], l2c_datain.halves[1]} : l2c_datain;
      end
   endfunction

   task automatic report_fail(input string sig, input logic [255:0] exp, input logic [255:0] got);
      $display("Fail %s: expected %0h, got %0h", sig, exp, got);
      errors++;
   endtask

   // compare on the rising edge and then step the model
   always @(posedge clk) begin
      tcache_pkg::fmap_word_u exp0;
      tcache_pkg::fmap_word_u exp1;
      if (!rst_n) begin
         m_vld     = 1'b0;
         m_last    = 1'b0;
         m_hl      = 1'b0;
         m_out_vld = 1'b0;
         m_dly     = '0;
      end else begin
         checks++;
         exp0 = m_ch0;
         exp1 = m_ch1;
         if (dfifo_addr_odd && mode == tcache_pkg::mode_conv16_dfifo) begin
            exp0 = {l1b_datain_ch0.halves[0], m_ch0.halves[1]};
            exp1 = {l1b_datain_ch0.halves[1], m_ch1.halves[1]};
         end else if (dfifo_addr_odd && mode == tcache_pkg::mode_conv32_dfifo) begin
            exp0 = m_ch1;
            exp1 = l1b_datain_ch0;
         end
         if (ram_wr_vld !== m_vld) report_fail("ram_wr_vld", m_vld, ram_wr_vld);
         if (ram_wr_last !== m_last) report_fail("ram_wr_last", m_last, ram_wr_last);
         if (m_vld && ram_wr_ch0 !== exp0) report_fail("ram_wr_ch0", exp0, ram_wr_ch0);
         if (m_vld && !is_trans(mode) && ram_wr_ch1 !== exp1) begin
            report_fail("ram_wr_ch1", exp1, ram_wr_ch1);
         end
         if (l1b_dataout_vld2lsu !== (!is_trans(mode) && l2c_datain_vld)) begin
            report_fail("l1b_dataout_vld2lsu", !is_trans(mode) && l2c_datain_vld,
                        l1b_dataout_vld2lsu);
         end
         if (l1b_dataout_vld !== m_out_vld) report_fail("l1b_dataout_vld", m_out_vld,
                                                         l1b_dataout_vld);
         if (m_out_vld && l1b_dataout !== m_out) report_fail("l1b_dataout", m_out, l1b_dataout);
         expect_wr();
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > max_cycles) begin
         $display("timeout, the run did not finish within %0d cycles", max_cycles);
         $display("Errors found");
         $finish;
      end
   end

   task automatic drive_cycle(input logic beat, input logic last);
      logic [31:0] r;
      @(negedge clk);
      r = $random(seed);
      l1b_datain_ch0 = rand_word();
      l1b_datain_ch1 = rand_word();
      l2c_datain     = rand_word();
      if (is_trans(mode)) begin
         l1b_datain_vld_ch0 = 1'b0;
         l1b_datain_vld_ch1 = 1'b0;
         l1b_datain_last    = 1'b0;
         l2c_datain_vld     = beat;
         l2c_datain_last    = last;
      end else begin
         l1b_datain_vld_ch0 = beat & r[0];
         l1b_datain_vld_ch1 = beat & (r[1] | ~r[0]);   // one channel at least
         l1b_datain_last    = last;
         l2c_datain_vld     = r[2];   // bypass traffic alongside
         l2c_datain_last    = 1'b0;
      end
   endtask

   task automatic drive_beats(input int n, input logic dense);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         r = $random(seed);
         drive_cycle(dense | r[0], 1'b0);
      end
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         drive_cycle(1'b0, 1'b0);
      end
   endtask

   task automatic start_test(input string name, input logic [2:0] m, input logic odd,
                             input logic stride, input logic [4:0] offs, input logic prici,
                             input logic swbank);
      @(negedge clk);
      mode               = m;
      dfifo_addr_odd     = odd;
      mvfmap_stride      = stride;
      mvfmap_offset      = offs;
      trans_prici        = prici;
      trans_swbank       = swbank;
      l1b_datain_vld_ch0 = 1'b0;
      l1b_datain_vld_ch1 = 1'b0;
      l1b_datain_last    = 1'b0;
      l2c_datain_vld     = 1'b0;
      l2c_datain_last    = 1'b0;
      test_name = name;
      test_err0 = errors;
   endtask

   task automatic end_test();
      idle_cycles(8);   // lets the last writes drain
      tests++;
      if (errors == test_err0) $display("test %s: ok", test_name);
      else $display("test %s: %0d mismatches", test_name, errors - test_err0);
   endtask

   initial begin
      int lat;
      rst_n              = 1'b0;
      mode               = tcache_pkg::mode_conv32_dfifo;
      trans_prici        = 1'b0;
      trans_swbank       = 1'b0;
      dfifo_addr_odd     = 1'b0;
      mvfmap_offset      = '0;
      mvfmap_stride      = 1'b0;
      l1b_datain_vld_ch0 = 1'b0;
      l1b_datain_vld_ch1 = 1'b0;
      l1b_datain_last    = 1'b0;
      l1b_datain_ch0     = '0;
      l1b_datain_ch1     = '0;
      l2c_datain_vld     = 1'b0;
      l2c_datain_last    = 1'b0;
      l2c_datain         = '0;
      repeat (rst_cycles) @(negedge clk);
      rst_n = 1'b1;

      start_test("dfifo32 even", tcache_pkg::mode_conv32_dfifo, 0, 0, 5'd0, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();
      start_test("dfifo32 odd", tcache_pkg::mode_conv32_dfifo, 1, 0, 5'd0, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();
      start_test("dfifo16 even", tcache_pkg::mode_conv16_dfifo, 0, 0, 5'd0, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();
      start_test("dfifo16 odd", tcache_pkg::mode_conv16_dfifo, 1, 0, 5'd0, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();

      // seven beats leave a half pair for the last to flush
      start_test("sfifo32 pairs", tcache_pkg::mode_conv32_sfifo, 0, 0, 5'd0, 0, 0);
      drive_beats(n_beats, 1'b0);
      drive_cycle(1'b0, 1'b1);
      idle_cycles(6);
      drive_beats(7, 1'b1);
      drive_cycle(1'b0, 1'b1);
      end_test();

      // tail beat lands together with the delayed last
      start_test("sfifo16 pairs", tcache_pkg::mode_conv16_sfifo, 0, 0, 5'd0, 0, 0);
      drive_beats(n_beats, 1'b0);
      drive_cycle(1'b0, 1'b1);
      idle_cycles(6);
      drive_beats(6, 1'b1);
      drive_cycle(1'b0, 1'b1);
      idle_cycles(tcache_pkg::last_dly - 1);
      drive_cycle(1'b1, 1'b0);
      end_test();

      start_test("sfifo16 stride even", tcache_pkg::mode_conv16_sfifo, 0, 1, 5'd6, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();
      start_test("sfifo16 stride odd", tcache_pkg::mode_conv16_sfifo, 0, 1, 5'd13, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();
      start_test("sfifo32 stride odd", tcache_pkg::mode_conv32_sfifo, 0, 1, 5'd13, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();

      start_test("trans plain", tcache_pkg::mode_trans_matrix, 0, 0, 5'd0, 0, 1);
      drive_beats(n_beats, 1'b0);
      drive_cycle(1'b1, 1'b1);
      end_test();
      start_test("trans swizzle", tcache_pkg::mode_trans_dwconv, 0, 0, 5'd0, 1, 0);
      drive_beats(n_beats, 1'b0);
      drive_cycle(1'b1, 1'b1);
      end_test();

      start_test("l1 last latency", tcache_pkg::mode_conv32_sfifo, 0, 0, 5'd0, 0, 0);
      drive_beats(5, 1'b1);
      drive_cycle(1'b0, 1'b1);
      lat = 0;
      while (!ram_wr_last && lat < 2 * tcache_pkg::last_dly) begin
         idle_cycles(1);
         lat++;
      end
      if (lat != tcache_pkg::last_dly + 1) begin
         $display("ram_wr_last came %0d cycles after the l1 last instead of %0d",
                  lat, tcache_pkg::last_dly + 1);
         errors++;
      end
      drive_beats(3, 1'b1);   // toggle starts low again
      end_test();

      start_test("bypass no swap", tcache_pkg::mode_conv16_dfifo, 0, 0, 5'd0, 0, 0);
      drive_beats(n_beats, 1'b0);
      end_test();
      start_test("bypass swap", tcache_pkg::mode_conv32_sfifo, 0, 0, 5'd0, 0, 1);
      drive_beats(n_beats, 1'b0);
      drive_cycle(1'b0, 1'b1);
      end_test();

      $display("tests %0d, cycles checked %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* sim/tcache_core_sva.sv */
module tcache_core_sva (
   input logic                          clk,
   input logic                          rst_n,
   input logic [tcache_pkg::mode_w-1:0] mode,
   input logic                          l2c_datain_vld,
   input logic                          l1b_datain_last,
   input logic                          ram_wr_vld,
   input logic                          ram_wr_last,
   input logic                          l1b_dataout_vld
);

   timeunit 1ns;
   timeprecision 100ps;

   logic fifo_mode;

   assign fifo_mode = (mode != tcache_pkg::mode_trans_matrix) &&
                      (mode != tcache_pkg::mode_trans_dwconv);

   // registered strobe must come out of reset low
   a_no_write_in_reset: assert property (@(posedge clk) !rst_n |=> !ram_wr_vld)
      else $error("ram_wr_vld high while in reset");

   a_bypass_vld: assert property (@(posedge clk) disable iff (!rst_n)
      (fifo_mode && l2c_datain_vld) |=> l1b_dataout_vld)
      else $error("l1b_dataout_vld missing one cycle after l2c_datain_vld");

   a_bypass_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      !(fifo_mode && l2c_datain_vld) |=> !l1b_dataout_vld)
      else $error("l1b_dataout_vld without a level-2 beat in fifo mode");

   a_l1_last_latency: assert property (@(posedge clk) disable iff (!rst_n)
      (fifo_mode && l1b_datain_last) |-> ##(tcache_pkg::last_dly + 1) ram_wr_last)
      else $error("l1 last did not reach ram_wr_last after the delay line");

endmodule

bind tcache_core tcache_core_sva i_tcache_core_sva (
   .clk             (clk),
   .rst_n           (rst_n),
   .mode            (mode),
   .l2c_datain_vld  (l2c_datain_vld),
   .l1b_datain_last (l1b_datain_last),
   .ram_wr_vld      (ram_wr_vld),
   .ram_wr_last     (ram_wr_last),
   .l1b_dataout_vld (l1b_dataout_vld)
);

/* source/tcache_core.sv */
module tcache_core (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [tcache_pkg::mode_w-1:0]    mode,
   input  logic                             trans_prici,
   input  logic                             trans_swbank,
   input  logic                             dfifo_addr_odd,
   input  logic [4:0]                       mvfmap_offset,
   input  logic                             mvfmap_stride,
   // level-1 buffer
   input  logic                             l1b_datain_vld_ch0,
   input  logic                             l1b_datain_vld_ch1,
   input  logic                             l1b_datain_last,
   input  logic [tcache_pkg::word_bits-1:0] l1b_datain_ch0,
   input  logic [tcache_pkg::word_bits-1:0] l1b_datain_ch1,
   // level-2 cache
   input  logic                             l2c_datain_vld,
   input  logic                             l2c_datain_last,
   input  logic [tcache_pkg::word_bits-1:0] l2c_datain,
   // ram write
   output logic                             ram_wr_vld,
   output logic                             ram_wr_last,
   output logic [tcache_pkg::word_bits-1:0] ram_wr_ch0,
   output logic [tcache_pkg::word_bits-1:0] ram_wr_ch1,
   // to level-1
   output logic                             l1b_dataout_vld2lsu,
   output logic                             l1b_dataout_vld,
   output logic [tcache_pkg::word_bits-1:0] l1b_dataout
);

   logic core_vld;
   logic core_last;
   logic hl_shift;

   tcache_wr_if wr_if ();

   tcache_ingress_ctrl i_ctrl (
      .clk                (clk),
      .rst_n              (rst_n),
      .mode               (mode),
      .mvfmap_stride      (mvfmap_stride),
      .l1b_datain_vld_ch0 (l1b_datain_vld_ch0),
      .l1b_datain_vld_ch1 (l1b_datain_vld_ch1),
      .l1b_datain_last    (l1b_datain_last),
      .l2c_datain_vld     (l2c_datain_vld),
      .l2c_datain_last    (l2c_datain_last),
      .core_vld           (core_vld),
      .core_last          (core_last),
      .hl_shift           (hl_shift),
      .wr                 (wr_if.ctrl)
   );

   tcache_word_packer i_packer (
      .clk                (clk),
      .mode               (mode),
      .core_vld           (core_vld),
      .core_last          (core_last),
      .hl_shift           (hl_shift),
      .trans_prici        (trans_prici),
      .mvfmap_stride      (mvfmap_stride),
      .dfifo_addr_odd     (dfifo_addr_odd),
      .l1b_datain_vld_ch0 (l1b_datain_vld_ch0),
      .mvfmap_offset0     (mvfmap_offset[0]),   // only parity matters here
      .l1b_datain_ch0     (l1b_datain_ch0),
      .l1b_datain_ch1     (l1b_datain_ch1),
      .l2c_datain         (l2c_datain),
      .wr                 (wr_if.packer)
   );

   tcache_l2c_bypass i_bypass (
      .clk                 (clk),
      .rst_n               (rst_n),
      .mode                (mode),
      .l2c_datain_vld      (l2c_datain_vld),
      .trans_swbank        (trans_swbank),
      .l2c_datain          (l2c_datain),
      .l1b_dataout_vld2lsu (l1b_dataout_vld2lsu),
      .l1b_dataout_vld     (l1b_dataout_vld),
      .l1b_dataout         (l1b_dataout)
   );

   assign ram_wr_vld  = wr_if.vld;
   assign ram_wr_last = wr_if.last;
   assign ram_wr_ch0  = wr_if.ch0;
   assign ram_wr_ch1  = wr_if.ch1;

endmodule

/* source/tcache_l2c_bypass.sv */
module tcache_l2c_bypass (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [tcache_pkg::mode_w-1:0] mode,
   input  logic                          l2c_datain_vld,
   input  logic                          trans_swbank,
   input  tcache_pkg::fmap_word_u        l2c_datain,
   output logic                          l1b_dataout_vld2lsu,
   output logic                          l1b_dataout_vld,
   output tcache_pkg::fmap_word_u        l1b_dataout
);

   logic fifo_mode;

   assign fifo_mode = (mode != tcache_pkg::mode_trans_matrix) &&
                      (mode != tcache_pkg::mode_trans_dwconv);

   assign l1b_dataout_vld2lsu = fifo_mode & l2c_datain_vld;   // same-cycle notice to lsu

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         l1b_dataout_vld <= 1'b0;
      end else begin
         l1b_dataout_vld <= l1b_dataout_vld2lsu;
      end
   end

   always_ff @(posedge clk) begin
      if (l1b_dataout_vld2lsu) begin
         if (trans_swbank) begin
            l1b_dataout.halves[0] <= l2c_datain.halves[1];   // bank swap
            l1b_dataout.halves[1] <= l2c_datain.halves[0];
         end else begin
            l1b_dataout <= l2c_datain;
         end
      end
   end

endmodule

/* source/tcache_word_packer.sv */
module tcache_word_packer (
   input  logic                          clk,
   input  logic [tcache_pkg::mode_w-1:0] mode,
   input  logic                          core_vld,
   input  logic                          core_last,
   input  logic                          hl_shift,
   input  logic                          trans_prici,
   input  logic                          mvfmap_stride,
   input  logic                          dfifo_addr_odd,
   input  logic                          l1b_datain_vld_ch0,
   input  logic                          mvfmap_offset0,
   input  tcache_pkg::fmap_word_u        l1b_datain_ch0,
   input  tcache_pkg::fmap_word_u        l1b_datain_ch1,
   input  tcache_pkg::fmap_word_u        l2c_datain,
   tcache_wr_if.packer                   wr
);

   logic                   trans_mode;
   logic                   sfifo_mode;
   tcache_pkg::fmap_word_u sel_word;
   tcache_pkg::fmap_word_u swz_word;
   tcache_pkg::fmap_word_u ch0_nxt;
   tcache_pkg::fmap_word_u ch1_nxt;
   tcache_pkg::fmap_word_u ch0_r;
   tcache_pkg::fmap_word_u ch1_r;

   assign trans_mode = (mode == tcache_pkg::mode_trans_matrix) ||
                       (mode == tcache_pkg::mode_trans_dwconv);
   assign sfifo_mode = (mode == tcache_pkg::mode_conv16_sfifo) ||
                       (mode == tcache_pkg::mode_conv32_sfifo);

   assign sel_word = l1b_datain_vld_ch0 ? l1b_datain_ch0 : l1b_datain_ch1;

   // even bytes to the low 16, odd bytes to the high 16
   always_comb begin
      for (int n = 0; n < tcache_pkg::ch_x; n++) begin
         if (n < tcache_pkg::ch_x / 2) begin
            swz_word.bytes[n] = l2c_datain.bytes[2 * n];
         end else begin
            swz_word.bytes[n] = l2c_datain.bytes[2 * (n - tcache_pkg::ch_x / 2) + 1];
         end
      end
   end

   always_comb begin
      ch0_nxt = l1b_datain_ch0;   // 32ch dfifo
      ch1_nxt = l1b_datain_ch1;
      if (trans_mode) begin
         ch0_nxt = trans_prici ? swz_word : l2c_datain;
         ch1_nxt = ch0_nxt;
      end else if (mode == tcache_pkg::mode_conv16_dfifo) begin
         ch0_nxt.halves[0] = l1b_datain_ch0.halves[0];
         ch0_nxt.halves[1] = l1b_datain_ch1.halves[0];
         ch1_nxt.halves[0] = l1b_datain_ch0.halves[1];
         ch1_nxt.halves[1] = l1b_datain_ch1.halves[1];
      end else if (sfifo_mode && mvfmap_stride) begin
         if (mode == tcache_pkg::mode_conv16_sfifo) begin
            ch0_nxt = '0;
            ch1_nxt = '0;
            ch0_nxt.halves[mvfmap_offset0] = sel_word.halves[0];
            ch1_nxt.halves[mvfmap_offset0] = sel_word.halves[1];
         end else begin
            ch0_nxt = mvfmap_offset0 ? '0 : sel_word;
            ch1_nxt = mvfmap_offset0 ? sel_word : '0;
         end
      end else if (mode == tcache_pkg::mode_conv16_sfifo) begin
         if (core_last && !hl_shift) begin
            // unpaired tail beat lands low
            ch0_nxt.halves[1] = ch0_r.halves[1];
            ch0_nxt.halves[0] = sel_word.halves[0];
            ch1_nxt.halves[1] = ch1_r.halves[1];
            ch1_nxt.halves[0] = sel_word.halves[1];
         end else begin
            ch0_nxt.halves[1] = sel_word.halves[0];   // shift in at top
            ch0_nxt.halves[0] = ch0_r.halves[1];
            ch1_nxt.halves[1] = sel_word.halves[1];
            ch1_nxt.halves[0] = ch1_r.halves[1];
         end
      end else if (mode == tcache_pkg::mode_conv32_sfifo) begin
         ch0_nxt = hl_shift ? ch0_r : sel_word;
         ch1_nxt = hl_shift ? sel_word : ch1_r;
      end
   end

   always_ff @(posedge clk) begin
      if (core_vld) begin
         ch0_r <= ch0_nxt;
         ch1_r <= ch1_nxt;
      end
   end

   // odd address: ch0 holds the even slot, ch0_r high the odd one
   always_comb begin
      wr.ch0 = ch0_r;
      wr.ch1 = ch1_r;
      if (dfifo_addr_odd) begin
         if (mode == tcache_pkg::mode_conv16_dfifo) begin
            wr.ch0 = {l1b_datain_ch0.halves[0], ch0_r.halves[1]};
            wr.ch1 = {l1b_datain_ch0.halves[1], ch1_r.halves[1]};
         end else if (mode == tcache_pkg::mode_conv32_dfifo) begin
            wr.ch0 = ch1_r;
            wr.ch1 = l1b_datain_ch0;
         end
      end
   end

endmodule

/* source/tcache_ingress_ctrl.sv */
module tcache_ingress_ctrl (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [tcache_pkg::mode_w-1:0] mode,
   input  logic                          mvfmap_stride,
   input  logic                          l1b_datain_vld_ch0,
   input  logic                          l1b_datain_vld_ch1,
   input  logic                          l1b_datain_last,
   input  logic                          l2c_datain_vld,
   input  logic                          l2c_datain_last,
   output logic                          core_vld,
   output logic                          core_last,
   output logic                          hl_shift,
   tcache_wr_if.ctrl                     wr
);

   logic                            trans_mode;
   logic                            sfifo_mode;
   logic [tcache_pkg::last_dly-1:0] last_dly_r;

   assign trans_mode = (mode == tcache_pkg::mode_trans_matrix) ||
                       (mode == tcache_pkg::mode_trans_dwconv);
   assign sfifo_mode = (mode == tcache_pkg::mode_conv16_sfifo) ||
                       (mode == tcache_pkg::mode_conv32_sfifo);

   // source select
   assign core_vld  = trans_mode ? l2c_datain_vld
                                 : (l1b_datain_vld_ch0 | l1b_datain_vld_ch1);
   assign core_last = trans_mode ? l2c_datain_last
                                 : last_dly_r[tcache_pkg::last_dly-1];

   // l1 last lags the data path, realign it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_dly_r <= '0;
      end else begin
         last_dly_r <= {last_dly_r[tcache_pkg::last_dly-2:0], l1b_datain_last};
      end
   end

   // high/low beat pairing in single fifo
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hl_shift <= 1'b0;
      end else if (core_last) begin
         hl_shift <= 1'b0;
      end else if (core_vld && sfifo_mode) begin
         hl_shift <= ~hl_shift;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr.vld  <= 1'b0;
         wr.last <= 1'b0;
      end else begin
         if (sfifo_mode && !mvfmap_stride) begin
            wr.vld <= (core_vld & hl_shift) | core_last;   // write on second beat or flush
         end else begin
            wr.vld <= core_vld;
         end
         wr.last <= core_last;
      end
   end

endmodule

/* source/tcache_wr_if.sv */
interface tcache_wr_if;

   logic                             vld;
   logic                             last;
   logic [tcache_pkg::word_bits-1:0] ch0;
   logic [tcache_pkg::word_bits-1:0] ch1;

   modport ctrl (
      output vld,
      output last
   );

   modport packer (
      output ch0,
      output ch1
   );

   modport sink (
      input vld,
      input last,
      input ch0,
      input ch1
   );

endinterface

/* source/tcache_pkg.sv */
package tcache_pkg;

   localparam int word_wid  = 8;                  // bits per channel byte
   localparam int ch_x      = 32;                 // channels per word
   localparam int word_bits = word_wid * ch_x;
   localparam int half_bits = word_bits / 2;      // one 16-channel bank
   localparam int last_dly  = 4;                  // l1 last strobe latency

   localparam int mode_w = 3;

   // fifo modes, level-1 buffer is the source
   localparam logic [mode_w-1:0] mode_conv16_dfifo = 3'b000;
   localparam logic [mode_w-1:0] mode_conv16_sfifo = 3'b001;
   localparam logic [mode_w-1:0] mode_conv32_dfifo = 3'b010;
   localparam logic [mode_w-1:0] mode_conv32_sfifo = 3'b011;

   // transpose modes, level-2 cache is the source
   localparam logic [mode_w-1:0] mode_trans_matrix = 3'b100;
   localparam logic [mode_w-1:0] mode_trans_dwconv = 3'b111;

   // one feature-map word seen as bytes or as two banks
   typedef union packed {
      logic [ch_x-1:0][word_wid-1:0] bytes;
      logic [1:0][half_bits-1:0]     halves;    // [0] bank0 low, [1] bank1 high
   } fmap_word_u;

endpackage
